//--- verilog/lc4_pkg.sv
package lc4_pkg;

    localparam int WORD_W   = 16;                        // datapath and address width
    localparam int NUM_REGS = 8;

    typedef logic [WORD_W-1:0]           word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_sel_t;
    typedef logic [2:0]                  nzp_t;          // {n, z, p}

    // trace stall codes, 1 is left unused since there is no second pipe
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_FLUSH = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_t;

    localparam word_t      PC_RESET = 16'h8200;
    localparam logic [3:0] OP_BR    = 4'b0000;
    localparam logic [3:0] OP_ADD   = 4'b0001;
    localparam logic [3:0] OP_LDR   = 4'b0110;
    localparam logic [3:0] OP_STR   = 4'b0111;
    localparam logic [3:0] OP_CONST = 4'b1001;

    typedef struct packed {
        logic r1re;       // reads rs
        logic r2re;       // reads rt
        logic rf_we;      // writes rd
        logic nzp_we;
        logic is_load;
        logic is_store;
        logic is_branch;
    } ctrl_t;

    typedef struct packed {
        word_t  pc;
        word_t  insn;
        stall_t stall;
    } fd_t;

    typedef struct packed {
        word_t    pc;
        word_t    insn;
        word_t    rs_data;                                // regfile values read in decode
        word_t    rt_data;
        reg_sel_t r1_sel;
        reg_sel_t r2_sel;
        reg_sel_t rd_sel;
        ctrl_t    ctrl;
        stall_t   stall;
    } dx_t;

    typedef struct packed {
        word_t    pc;
        word_t    insn;
        word_t    alu;                                    // sum, constant or address
        word_t    store_data;
        reg_sel_t rd_sel;
        reg_sel_t rt_sel;                                 // kept for the WM check
        ctrl_t    ctrl;
        stall_t   stall;
    } xm_t;

    typedef struct packed {
        word_t    pc;
        word_t    insn;
        word_t    wdata;                                  // value headed for rd
        reg_sel_t rd_sel;
        nzp_t     nzp;
        word_t    store_data;
        word_t    dmem_addr;
        ctrl_t    ctrl;
        stall_t   stall;
    } mw_t;

    // empty slots, also the reset contents of every stage
    localparam fd_t FD_BUBBLE = '{stall: STALL_FLUSH, default: '0};
    localparam dx_t DX_BUBBLE = '{stall: STALL_FLUSH, default: '0};
    localparam xm_t XM_BUBBLE = '{stall: STALL_FLUSH, default: '0};
    localparam mw_t MW_BUBBLE = '{stall: STALL_FLUSH, default: '0};

    // sign of a result as nzp bits
    function automatic nzp_t nzp_of(input word_t v);
        if (v[WORD_W-1]) return 3'b100;
        if (v == '0) return 3'b010;
        return 3'b001;
    endfunction

endpackage

//--- verilog/lc4_decoder.sv
`timescale 1ns/1ps

module lc4_decoder (
    input  lc4_pkg::word_t    i_insn,
    output lc4_pkg::reg_sel_t o_r1_sel,
    output lc4_pkg::reg_sel_t o_r2_sel,
    output lc4_pkg::reg_sel_t o_rd_sel,
    output lc4_pkg::ctrl_t    o_ctrl
);

    logic [3:0] opcode;

    assign opcode = i_insn[15:12];

    // field positions are the same for the whole subset
    assign o_r1_sel = i_insn[8:6];                        // rs
    assign o_rd_sel = i_insn[11:9];                       // rd
    // a store names its data register where the others put rd
    assign o_r2_sel = (opcode == lc4_pkg::OP_STR) ? i_insn[11:9] : i_insn[2:0];

    always_comb begin
        o_ctrl = '0;                                      // anything unknown is a nop
        case (opcode)
            lc4_pkg::OP_ADD: begin
                o_ctrl.r1re   = 1'b1;
                o_ctrl.r2re   = ~i_insn[5];               // bit 5 set means imm5
                o_ctrl.rf_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            lc4_pkg::OP_CONST: begin
                o_ctrl.rf_we  = 1'b1;                     // no source regs
                o_ctrl.nzp_we = 1'b1;
            end
            lc4_pkg::OP_LDR: begin
                o_ctrl.r1re    = 1'b1;                    // base
                o_ctrl.rf_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            lc4_pkg::OP_STR: begin
                o_ctrl.r1re     = 1'b1;                   // base
                o_ctrl.r2re     = 1'b1;                   // data
                o_ctrl.is_store = 1'b1;
            end
            lc4_pkg::OP_BR: begin
                o_ctrl.is_branch = 1'b1;                  // nzp field 000 never takes
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

//--- verilog/lc4_alu.sv
`timescale 1ns/1ps

module lc4_alu (
    input  lc4_pkg::word_t i_insn,
    input  lc4_pkg::word_t i_pc,
    input  lc4_pkg::word_t i_r1_data,
    input  lc4_pkg::word_t i_r2_data,
    output lc4_pkg::word_t o_result
);

    lc4_pkg::word_t imm5;
    lc4_pkg::word_t imm6;
    lc4_pkg::word_t imm9;

    // sign extended immediates
    assign imm5 = {{(lc4_pkg::WORD_W-5){i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{(lc4_pkg::WORD_W-6){i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{(lc4_pkg::WORD_W-9){i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        case (i_insn[15:12])
            lc4_pkg::OP_ADD: begin
                o_result = i_insn[5] ? (i_r1_data + imm5) : (i_r1_data + i_r2_data);
            end
            lc4_pkg::OP_CONST: begin
                o_result = imm9;
            end
            lc4_pkg::OP_LDR, lc4_pkg::OP_STR: begin
                o_result = i_r1_data + imm6;              // effective address
            end
            lc4_pkg::OP_BR: begin
                o_result = i_pc + 16'd1 + imm9;           // target, used only when taken
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

//--- verilog/lc4_regfile.sv
`timescale 1ns/1ps

module lc4_regfile (
    input  logic              gwe,
    input  logic              i_reset,
    input  lc4_pkg::reg_sel_t i_rs_sel,
    input  lc4_pkg::reg_sel_t i_rt_sel,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data,
    input  lc4_pkg::reg_sel_t i_rd_sel,
    input  lc4_pkg::word_t    i_wdata,
    input  logic              i_we
);

    lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd_sel] <= i_wdata;
        end
    end

    // writeback value shows up in decode the same cycle
    assign o_rs_data = (i_we && (i_rd_sel == i_rs_sel)) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_we && (i_rd_sel == i_rt_sel)) ? i_wdata : regs[i_rt_sel];

endmodule

//--- verilog/lc4_stage_reg.sv
`timescale 1ns/1ps

// one pipeline latch, payload type chosen per stage
module lc4_stage_reg #(
    parameter type T      = logic [0:0],
    parameter T    BUBBLE = T'(0)
) (
    input  logic gwe,
    input  logic i_reset,
    input  logic i_hold,                                  // keep current contents
    input  logic i_kill,                                  // replace with a bubble
    input  T     i_data,
    output T     o_data
);

    always_ff @(posedge gwe) begin
        if (i_reset || i_kill) begin
            o_data <= BUBBLE;                             // kill beats hold
        end else if (!i_hold) begin
            o_data <= i_data;
        end
    end

endmodule

//--- verilog/lc4_hazard_unit.sv
`timescale 1ns/1ps

module lc4_hazard_unit (
    input  lc4_pkg::reg_sel_t i_d_r1_sel,
    input  lc4_pkg::reg_sel_t i_d_r2_sel,
    input  lc4_pkg::ctrl_t    i_d_ctrl,
    input  lc4_pkg::reg_sel_t i_x_rd_sel,
    input  lc4_pkg::ctrl_t    i_x_ctrl,
    input  lc4_pkg::word_t    i_x_insn,
    input  lc4_pkg::nzp_t     i_x_nzp,
    output logic              o_load_stall,
    output logic              o_branch_taken
);

    logic use_r1;
    logic use_r2;
    logic x_load;

    // bubbles reach here with every ctrl flag clear, so they never match
    assign x_load = i_x_ctrl.is_load;

    assign use_r1 = i_d_ctrl.r1re && (i_d_r1_sel == i_x_rd_sel);
    // store data can wait for the WM path, so it does not count
    assign use_r2 = i_d_ctrl.r2re && !i_d_ctrl.is_store && (i_d_r2_sel == i_x_rd_sel);

    // a branch behind a load waits a cycle so that it sees the load's nzp from memory
    assign o_load_stall = x_load && (use_r1 || use_r2 || i_d_ctrl.is_branch);

    // condition field of BR against the youngest nzp
    assign o_branch_taken = i_x_ctrl.is_branch && |(i_x_insn[11:9] & i_x_nzp);

endmodule

//--- verilog/lc4_bypass_net.sv
`timescale 1ns/1ps

module lc4_bypass_net (
    input  lc4_pkg::dx_t   i_x_payload,
    input  lc4_pkg::xm_t   i_m_payload,
    input  lc4_pkg::word_t i_m_wdata,                     // load data or alu result
    input  lc4_pkg::mw_t   i_w_payload,
    input  lc4_pkg::nzp_t  i_nzp_reg,
    output lc4_pkg::word_t o_rs_data,
    output lc4_pkg::word_t o_rt_data,
    output lc4_pkg::word_t o_m_store_data,
    output lc4_pkg::nzp_t  o_x_nzp
);

    logic m_rf_we;
    logic w_rf_we;
    logic mx_rs, mx_rt;
    logic wx_rs, wx_rt;
    logic wm_rt;

    assign m_rf_we = i_m_payload.ctrl.rf_we;
    assign w_rf_we = i_w_payload.ctrl.rf_we;

    // MX
    assign mx_rs = m_rf_we && (i_m_payload.rd_sel == i_x_payload.r1_sel);
    assign mx_rt = m_rf_we && (i_m_payload.rd_sel == i_x_payload.r2_sel);
    // WX
    assign wx_rs = w_rf_we && (i_w_payload.rd_sel == i_x_payload.r1_sel);
    assign wx_rt = w_rf_we && (i_w_payload.rd_sel == i_x_payload.r2_sel);

    // younger producer first, MX carries the alu value only
    // a load in memory can only feed store data here, which WM repairs a cycle later
    assign o_rs_data = mx_rs ? i_m_payload.alu :
                       wx_rs ? i_w_payload.wdata : i_x_payload.rs_data;
    assign o_rt_data = mx_rt ? i_m_payload.alu :
                       wx_rt ? i_w_payload.wdata : i_x_payload.rt_data;

    // WM, covers a load followed directly by a store of its result
    assign wm_rt = i_m_payload.ctrl.is_store && w_rf_we &&
                   (i_w_payload.rd_sel == i_m_payload.rt_sel);
    assign o_m_store_data = wm_rt ? i_w_payload.wdata : i_m_payload.store_data;

    // nzp seen by a branch in execute
    always_comb begin
        if (i_m_payload.ctrl.nzp_we) begin
            o_x_nzp = lc4_pkg::nzp_of(i_m_wdata);         // not latched yet
        end else if (i_w_payload.ctrl.nzp_we) begin
            o_x_nzp = i_w_payload.nzp;
        end else begin
            o_x_nzp = i_nzp_reg;
        end
    end

endmodule

//--- verilog/lc4_pipeline.sv
`timescale 1ns/1ps

module lc4_pipeline (
    input  logic              gwe,
    input  logic              i_reset,
    output lc4_pkg::word_t    o_imem_addr,
    input  lc4_pkg::word_t    i_imem_insn,
    output lc4_pkg::word_t    o_dmem_addr,
    output lc4_pkg::word_t    o_dmem_wdata,
    output logic              o_dmem_we,
    input  lc4_pkg::word_t    i_dmem_rdata,
    output lc4_pkg::word_t    o_wb_pc,
    output lc4_pkg::word_t    o_wb_insn,
    output lc4_pkg::stall_t   o_wb_stall,
    output logic              o_wb_rf_we,
    output lc4_pkg::reg_sel_t o_wb_rf_sel,
    output lc4_pkg::word_t    o_wb_rf_data,
    output logic              o_wb_nzp_we,
    output lc4_pkg::nzp_t     o_wb_nzp,
    output logic              o_wb_dmem_we
);

    lc4_pkg::word_t    f_pc;
    lc4_pkg::fd_t      fd_d, fd_q;
    lc4_pkg::dx_t      dx_d, dx_q;
    lc4_pkg::xm_t      xm_d, xm_q;
    lc4_pkg::mw_t      mw_d, mw_q;
    lc4_pkg::reg_sel_t d_r1_sel, d_r2_sel, d_rd_sel;
    lc4_pkg::ctrl_t    d_dec_ctrl, d_ctrl;
    lc4_pkg::word_t    d_rs_data, d_rt_data;
    lc4_pkg::word_t    x_rs_data, x_rt_data, x_alu;
    lc4_pkg::nzp_t     x_nzp, nzp_reg;
    lc4_pkg::word_t    m_wdata, m_store_data;
    logic              load_stall, branch_taken;

    // fetch, a taken branch overrides the load stall
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            f_pc <= lc4_pkg::PC_RESET;
        end else if (branch_taken) begin
            f_pc <= x_alu;                                // target from execute
        end else if (!load_stall) begin
            f_pc <= f_pc + 16'd1;
        end
    end
    assign o_imem_addr = f_pc;
    assign fd_d = '{pc: f_pc, insn: i_imem_insn, stall: lc4_pkg::STALL_NONE};

    lc4_stage_reg #(.T(lc4_pkg::fd_t), .BUBBLE(lc4_pkg::FD_BUBBLE)) u_fd_reg (
        .gwe(gwe), .i_reset(i_reset), .i_hold(load_stall), .i_kill(branch_taken),
        .i_data(fd_d), .o_data(fd_q)
    );

    // decode
    lc4_decoder u_decoder (
        .i_insn(fd_q.insn), .o_r1_sel(d_r1_sel), .o_r2_sel(d_r2_sel),
        .o_rd_sel(d_rd_sel), .o_ctrl(d_dec_ctrl)
    );
    assign d_ctrl = (fd_q.stall == lc4_pkg::STALL_NONE) ? d_dec_ctrl : '0;  // bubble is inert

    lc4_regfile u_regfile (
        .gwe(gwe), .i_reset(i_reset),
        .i_rs_sel(d_r1_sel), .i_rt_sel(d_r2_sel),
        .o_rs_data(d_rs_data), .o_rt_data(d_rt_data),
        .i_rd_sel(mw_q.rd_sel), .i_wdata(mw_q.wdata), .i_we(mw_q.ctrl.rf_we)
    );

    // on a load stall the decode slot goes down as a load bubble and stays put
    assign dx_d = '{pc: fd_q.pc, insn: fd_q.insn,
                    rs_data: d_rs_data, rt_data: d_rt_data,
                    r1_sel: d_r1_sel, r2_sel: d_r2_sel, rd_sel: d_rd_sel,
                    ctrl: load_stall ? '0 : d_ctrl,
                    stall: load_stall ? lc4_pkg::STALL_LOAD : fd_q.stall};

    lc4_stage_reg #(.T(lc4_pkg::dx_t), .BUBBLE(lc4_pkg::DX_BUBBLE)) u_dx_reg (
        .gwe(gwe), .i_reset(i_reset), .i_hold(1'b0), .i_kill(branch_taken),
        .i_data(dx_d), .o_data(dx_q)
    );

    // execute
    lc4_bypass_net u_bypass (
        .i_x_payload(dx_q), .i_m_payload(xm_q), .i_m_wdata(m_wdata),
        .i_w_payload(mw_q), .i_nzp_reg(nzp_reg),
        .o_rs_data(x_rs_data), .o_rt_data(x_rt_data),
        .o_m_store_data(m_store_data), .o_x_nzp(x_nzp)
    );

    lc4_alu u_alu (
        .i_insn(dx_q.insn), .i_pc(dx_q.pc),
        .i_r1_data(x_rs_data), .i_r2_data(x_rt_data), .o_result(x_alu)
    );

    lc4_hazard_unit u_hazard (
        .i_d_r1_sel(d_r1_sel), .i_d_r2_sel(d_r2_sel), .i_d_ctrl(d_ctrl),
        .i_x_rd_sel(dx_q.rd_sel), .i_x_ctrl(dx_q.ctrl), .i_x_insn(dx_q.insn),
        .i_x_nzp(x_nzp), .o_load_stall(load_stall), .o_branch_taken(branch_taken)
    );

    assign xm_d = '{pc: dx_q.pc, insn: dx_q.insn, alu: x_alu, store_data: x_rt_data,
                    rd_sel: dx_q.rd_sel, rt_sel: dx_q.r2_sel,
                    ctrl: dx_q.ctrl, stall: dx_q.stall};

    lc4_stage_reg #(.T(lc4_pkg::xm_t), .BUBBLE(lc4_pkg::XM_BUBBLE)) u_xm_reg (
        .gwe(gwe), .i_reset(i_reset), .i_hold(1'b0), .i_kill(1'b0),
        .i_data(xm_d), .o_data(xm_q)
    );

    // memory
    assign m_wdata      = xm_q.ctrl.is_load ? i_dmem_rdata : xm_q.alu;
    assign o_dmem_addr  = (xm_q.ctrl.is_load || xm_q.ctrl.is_store) ? xm_q.alu : '0;
    assign o_dmem_we    = xm_q.ctrl.is_store;
    assign o_dmem_wdata = m_store_data;                   // WM already applied

    assign mw_d = '{pc: xm_q.pc, insn: xm_q.insn, wdata: m_wdata, rd_sel: xm_q.rd_sel,
                    nzp: lc4_pkg::nzp_of(m_wdata), store_data: m_store_data,
                    dmem_addr: o_dmem_addr, ctrl: xm_q.ctrl, stall: xm_q.stall};

    lc4_stage_reg #(.T(lc4_pkg::mw_t), .BUBBLE(lc4_pkg::MW_BUBBLE)) u_mw_reg (
        .gwe(gwe), .i_reset(i_reset), .i_hold(1'b0), .i_kill(1'b0),
        .i_data(mw_d), .o_data(mw_q)
    );

    // writeback, nzp commits here
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            nzp_reg <= '0;
        end else if (mw_q.ctrl.nzp_we) begin
            nzp_reg <= mw_q.nzp;
        end
    end

    assign o_wb_pc      = mw_q.pc;
    assign o_wb_insn    = mw_q.insn;
    assign o_wb_stall   = mw_q.stall;
    assign o_wb_rf_we   = mw_q.ctrl.rf_we;
    assign o_wb_rf_sel  = mw_q.rd_sel;
    assign o_wb_rf_data = mw_q.wdata;
    assign o_wb_nzp_we  = mw_q.ctrl.nzp_we;
    assign o_wb_nzp     = mw_q.nzp;
    assign o_wb_dmem_we = mw_q.ctrl.is_store;

endmodule

//--- verif/lc4_pipeline_chk.sv
`timescale 1ns/1ps

// protocol checks on the top-level trace and memory outputs
module lc4_pipeline_chk (
    input logic            gwe,
    input logic            i_reset,
    input logic            o_dmem_we,
    input lc4_pkg::stall_t o_wb_stall,
    input logic            o_wb_rf_we,
    input logic            o_wb_nzp_we,
    input logic            o_wb_dmem_we
);

    // memory stage holds a bubble right after reset
    a_no_store_after_reset: assert property (@(posedge gwe) i_reset |=> !o_dmem_we)
        else $error("data memory write enabled in the cycle after reset");

    // a bubble on the trace never writes anything
    a_bubble_is_inert: assert property (@(posedge gwe) disable iff (i_reset)
        (o_wb_stall != lc4_pkg::STALL_NONE) |-> !(o_wb_rf_we || o_wb_nzp_we || o_wb_dmem_we))
        else $error("trace bubble carries a write enable");

    // code 1 belonged to the second pipe
    a_no_pipe_b_code: assert property (@(posedge gwe) disable iff (i_reset)
        o_wb_stall != 2'd1)
        else $error("trace stall code 1 seen");

endmodule

bind lc4_pipeline lc4_pipeline_chk u_chk (
    .gwe(gwe), .i_reset(i_reset), .o_dmem_we(o_dmem_we), .o_wb_stall(o_wb_stall),
    .o_wb_rf_we(o_wb_rf_we), .o_wb_nzp_we(o_wb_nzp_we), .o_wb_dmem_we(o_wb_dmem_we)
);

//--- verif/lc4_pipeline_tb.sv
`timescale 1ns/1ps

module lc4_pipeline_tb;

    localparam int          CLK_PERIOD  = 8;
    localparam int          TOTAL_INSNS = 4 * 40 + 40;        // random plus directed programs
    localparam logic [31:0] SEED        = 32'h1b154450;

    typedef struct packed {
        lc4_pkg::word_t    pc;
        lc4_pkg::word_t    insn;
        logic              rf_we;
        lc4_pkg::reg_sel_t sel;
        lc4_pkg::word_t    data;
        logic              nzp_we;
        lc4_pkg::nzp_t     nzp;
        logic              dmem_we;
    } retire_t;

    logic gwe, i_reset, o_dmem_we, o_wb_rf_we, o_wb_nzp_we, o_wb_dmem_we;
    lc4_pkg::word_t    o_imem_addr, i_imem_insn, o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
    lc4_pkg::word_t    o_wb_pc, o_wb_insn, o_wb_rf_data;
    lc4_pkg::stall_t   o_wb_stall;
    lc4_pkg::reg_sel_t o_wb_rf_sel;
    lc4_pkg::nzp_t     o_wb_nzp;

    lc4_pkg::word_t imem [0:65535];
    lc4_pkg::word_t dmem [0:65535];
    lc4_pkg::word_t gmem [0:65535];                           // golden model data memory
    lc4_pkg::word_t prog [$];
    retire_t        exp_q [$];
    retire_t        act_q [$];
    int             flush_before [$];                         // bubbles seen before each retirement
    int             load_before [$];
    int             pend_flush, pend_load, mism, other;
    logic           collecting, pre_bad;
    logic [31:0]    lfsr;

    lc4_pipeline UUT (.*);

    initial begin
        gwe = 1'b0;
        forever #(CLK_PERIOD / 2) gwe = ~gwe;
    end

    assign i_imem_insn  = imem[o_imem_addr];                  // combinational memories
    assign i_dmem_rdata = dmem[o_dmem_addr];

    always @(posedge gwe) begin
        if (o_dmem_we) dmem[o_dmem_addr] <= o_dmem_wdata;
    end

    // trace monitor, sampled mid cycle where outputs are settled
    always @(negedge gwe) begin
        if (collecting && !i_reset) begin
            if (o_wb_stall == lc4_pkg::STALL_NONE) begin
                act_q.push_back({o_wb_pc, o_wb_insn, o_wb_rf_we, o_wb_rf_sel, o_wb_rf_data,
                                 o_wb_nzp_we, o_wb_nzp, o_wb_dmem_we});
                flush_before.push_back(pend_flush);
                load_before.push_back(pend_load);
                pend_flush = 0;
                pend_load  = 0;
            end else begin
                if (o_wb_stall == lc4_pkg::STALL_FLUSH) pend_flush++;
                else pend_load++;
                if (act_q.size() == 0 && (o_wb_stall != lc4_pkg::STALL_FLUSH ||
                    o_wb_rf_we || o_wb_nzp_we || o_wb_dmem_we || o_dmem_we)) pre_bad = 1'b1;
            end
        end
    end

    // galois lfsr, one step per bit
    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[14:0], lfsr_bit()};
        return v;
    endfunction

    function automatic lc4_pkg::word_t fill_word(input int a);
        return 16'(a * 3) ^ 16'h5a5a ^ {a[7:0], a[15:8]};      // whole address matters
    endfunction

    function automatic lc4_pkg::nzp_t sign_bits(input lc4_pkg::word_t v);
        if ($signed(v) < 0) return 3'b100;
        else if (v == 16'd0) return 3'b010;
        else return 3'b001;
    endfunction

    // fields that mean nothing for this instruction are zeroed
    function automatic retire_t masked(input retire_t e);
        retire_t m;
        m = e;
        if (!m.rf_we) begin
            m.sel  = '0;
            m.data = '0;
        end
        if (!m.nzp_we) m.nzp = '0;
        return m;
    endfunction

    function automatic lc4_pkg::word_t enc(input logic [3:0] op, input logic [2:0] a,
                                           input logic [8:0] rest);
        return {op, a, rest};
    endfunction

    // isa-level reference, one instruction per step
    task automatic golden_run(input int n);
        lc4_pkg::word_t r [8];
        lc4_pkg::word_t pc, insn, v, addr, next;
        lc4_pkg::nzp_t  nzp;
        retire_t        e;
        logic           wr;
        int             steps;
        pc    = lc4_pkg::PC_RESET;
        nzp   = 3'b000;
        steps = 0;
        foreach (r[i]) r[i] = '0;
        exp_q.delete();
        while (pc >= lc4_pkg::PC_RESET && int'(pc) < int'(lc4_pkg::PC_RESET) + n
               && steps < 4 * n) begin
            insn = imem[pc];
            e = '0;
            e.pc = pc;
            e.insn = insn;
            next = pc + 16'd1;
            wr = 1'b0;
            addr = r[insn[8:6]] + {{10{insn[5]}}, insn[5:0]};
            case (insn[15:12])
                4'b0001: begin
                    v  = r[insn[8:6]] + (insn[5] ? {{11{insn[4]}}, insn[4:0]} : r[insn[2:0]]);
                    wr = 1'b1;
                end
                4'b1001: begin
                    v  = {{7{insn[8]}}, insn[8:0]};
                    wr = 1'b1;
                end
                4'b0110: begin
                    v  = gmem[addr];
                    wr = 1'b1;
                end
                4'b0111: begin
                    gmem[addr] = r[insn[11:9]];
                    e.dmem_we  = 1'b1;
                end
                4'b0000: begin
                    if (|(insn[11:9] & nzp)) next = pc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
                end
                default: ;                                    // nop
            endcase
            if (wr) begin
                r[insn[11:9]] = v;
                nzp = sign_bits(v);
                e.rf_we = 1'b1;
                e.sel = insn[11:9];
                e.data = v;
                e.nzp_we = 1'b1;
                e.nzp = nzp;
            end
            exp_q.push_back(e);
            pc = next;
            steps++;
        end
    endtask

    task automatic run_program(input string name);
        int cycles;
        int bad_addr;
        collecting = 1'b0;
        @(posedge gwe);
        #1 i_reset = 1'b1;
        for (int a = 0; a < 65536; a++) begin
            imem[a] = '0;
            dmem[a] = fill_word(a);
            gmem[a] = fill_word(a);
        end
        foreach (prog[i]) imem[lc4_pkg::PC_RESET + i] = prog[i];
        golden_run(prog.size());
        act_q.delete();
        flush_before.delete();
        load_before.delete();
        pend_flush = 0;
        pend_load  = 0;
        pre_bad    = 1'b0;
        repeat (3) @(posedge gwe);
        #1 i_reset = 1'b0;
        collecting = 1'b1;
        cycles = 0;
        while (act_q.size() < exp_q.size() && cycles < 20 * prog.size() + 20) begin
            @(posedge gwe);
            cycles++;
        end
        @(negedge gwe);
        collecting = 1'b0;
        if (act_q.size() < exp_q.size()) begin
            other++;
            $display("%s: timed out with %0d of %0d retirements", name, act_q.size(),
                     exp_q.size());
        end
        for (int i = 0; i < exp_q.size() && i < act_q.size(); i++) begin
            if (masked(act_q[i]) != masked(exp_q[i])) begin
                mism++;
                $display("mismatch %s retirement %0d: expected %h actual %h", name, i,
                         masked(exp_q[i]), masked(act_q[i]));
            end
        end
        // a taken branch leaves two flush bubbles, a fall-through none
        for (int i = 0; i + 1 < exp_q.size() && i + 1 < act_q.size(); i++) begin
            if (exp_q[i].insn[15:12] == 4'b0000) begin
                if (flush_before[i+1] != ((exp_q[i+1].pc != exp_q[i].pc + 16'd1) ? 2 : 0)) begin
                    mism++;
                    $display("mismatch %s flush bubbles after branch at %h: expected %0d actual %0d",
                             name, exp_q[i].pc,
                             (exp_q[i+1].pc != exp_q[i].pc + 16'd1) ? 2 : 0, flush_before[i+1]);
                end
            end
        end
        bad_addr = -1;
        for (int a = 0; a < 65536 && bad_addr < 0; a++) begin
            if (dmem[a] != gmem[a]) bad_addr = a;
        end
        if (bad_addr >= 0) begin
            mism++;
            $display("mismatch %s dmem[%h]: expected %h actual %h", name, bad_addr[15:0],
                     gmem[bad_addr], dmem[bad_addr]);
        end
    endtask

    task automatic reset_entry();
        prog = '{enc(4'b1001, 3'd1, 9'd3), enc(4'b0001, 3'd2, {3'd1, 6'b100001})};
        run_program("reset");
        if (pre_bad) begin
            other++;
            $display("reset: entry before first retirement was not an inert flush bubble");
        end
        if (act_q.size() > 0 && act_q[0].pc != lc4_pkg::PC_RESET) begin
            mism++;
            $display("mismatch reset first pc: expected %h actual %h", lc4_pkg::PC_RESET,
                     act_q[0].pc);
        end
    endtask

    task automatic dependent_adds();
        prog = '{enc(4'b1001, 3'd1, 9'd5),                      // r1 = 5
                 enc(4'b0001, 3'd2, {3'd1, 3'b000, 3'd1}),      // mx on both operands
                 enc(4'b0001, 3'd3, {3'd2, 3'b000, 3'd1}),      // mx and wx
                 enc(4'b0001, 3'd4, {3'd3, 6'b110000}),         // r3 - 16
                 enc(4'b1001, 3'd5, 9'd0),
                 enc(4'b0001, 3'd6, {3'd5, 3'b000, 3'd4})};
        run_program("add_chain");
    endtask

    task automatic store_load_use();
        prog = '{enc(4'b1001, 3'd1, 9'h020),
                 enc(4'b1001, 3'd2, 9'h1f9),                    // -7
                 enc(4'b0111, 3'd2, {3'd1, 6'd3}),
                 enc(4'b0110, 3'd3, {3'd1, 6'd3}),
                 enc(4'b0001, 3'd4, {3'd3, 3'b000, 3'd3}),      // load-use
                 enc(4'b0110, 3'd5, {3'd1, 6'd3}),
                 enc(4'b0111, 3'd5, {3'd1, 6'd4}),              // store data over wm
                 enc(4'b0110, 3'd6, {3'd1, 6'd4})};
        run_program("store_load");
        if (load_before.size() > 4 && load_before[4] != 1) begin
            mism++;
            $display("mismatch store_load load bubbles before add: expected 1 actual %0d",
                     load_before[4]);
        end
    endtask

    task automatic branch_bubbles();
        prog = '{enc(4'b1001, 3'd1, 9'd1),
                 enc(4'b0000, 3'b001, 9'd2),                    // taken, skips two
                 enc(4'b1001, 3'd2, 9'd7),
                 enc(4'b1001, 3'd3, 9'd7),
                 enc(4'b0001, 3'd4, {3'd1, 6'b100001}),
                 enc(4'b0000, 3'b100, 9'd1),                    // not taken
                 enc(4'b0001, 3'd5, {3'd1, 6'b100010}),
                 enc(4'b1001, 3'd0, 9'h1ff),
                 enc(4'b1001, 3'd6, 9'h010),                    // positive nzp before the load
                 enc(4'b0111, 3'd0, {3'd6, 6'd0}),
                 enc(4'b0110, 3'd7, {3'd6, 6'd0}),
                 enc(4'b0000, 3'b100, 9'd1),                    // uses the load's nzp
                 enc(4'b1001, 3'd2, 9'd9),
                 enc(4'b0001, 3'd3, {3'd7, 6'b100001})};
        run_program("branches");
    endtask

    task automatic random_mix(input int k);
        logic [1:0] kind;
        prog.delete();
        for (int i = 0; i < 40; i++) begin
            kind = 2'(rand_bits(2));
            case (kind)
                2'd0: prog.push_back(enc(4'b0001, 3'(rand_bits(3)),
                                         {3'(rand_bits(3)), lfsr_bit(), 2'b00,
                                          3'(rand_bits(3))}));
                2'd1: prog.push_back(enc(4'b1001, 3'(rand_bits(3)), 9'(rand_bits(9))));
                2'd2: prog.push_back(enc(4'b0110, 3'(rand_bits(3)),
                                         {3'(rand_bits(3)), 6'(rand_bits(6))}));
                default: prog.push_back(enc(4'b0111, 3'(rand_bits(3)),
                                            {3'(rand_bits(3)), 6'(rand_bits(6))}));
            endcase
        end
        run_program($sformatf("random_%0d", k));
    endtask

    initial begin
        #(TOTAL_INSNS * 20 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        i_reset    = 1'b1;
        collecting = 1'b0;
        lfsr       = SEED;
        mism       = 0;
        other      = 0;
        for (int a = 0; a < 65536; a++) begin
            imem[a] = '0;                                     // known fetch data from time zero
            dmem[a] = '0;
        end
        reset_entry();
        dependent_adds();
        store_load_use();
        branch_bubbles();
        for (int k = 0; k < 4; k++) random_mix(k);
        $display("errors: %0d mismatches, %0d other failures", mism, other);
        if (mism == 0 && other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- filelist.f
verilog/lc4_pkg.sv
verilog/lc4_decoder.sv
verilog/lc4_alu.sv
verilog/lc4_regfile.sv
verilog/lc4_stage_reg.sv
verilog/lc4_hazard_unit.sv
verilog/lc4_bypass_net.sv
verilog/lc4_pipeline.sv
verif/lc4_pipeline_chk.sv
verif/lc4_pipeline_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lc4_pipeline_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG) || ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
